//--- Bender.yml
package:
  name: int_status_unit

sources:
  - include_dirs:
      - design
    files:
      - design/intStatusPkg.sv
      - design/statusReg.sv
      - design/intArbiter.sv
      - design/vectorSelect.sv
      - design/intStatusUnit.sv
  - target: test
    files:
      - testbench/intStatusTb.sv

//--- build.f
+incdir+design
design/intStatusPkg.sv
design/statusReg.sv
design/intArbiter.sv
design/vectorSelect.sv
design/intStatusUnit.sv
testbench/intStatusTb.sv

//--- design/intArbiter.sv
`timescale 1ns/1ps
`include "intStatus_params.svh"

module intArbiter
(
  input  logic                    CLK,
  input  logic                    RST_N,
  input  logic                    ce,
  input  logic                    rdyIn,
  input  logic                    nmiN,
  input  logic                    irqN,
  input  logic                    abortN,
  input  logic                    lastCycle,
  input  intStatusPkg::fetch_t    fetch,
  input  logic                    iFlag,
  output logic                    ready,
  output logic                    intTaken,
  output intStatusPkg::intKind_e  hwKind
);

  import intStatusPkg::*;

  logic oldNmiN;
  logic nmiSync;  // pending nmi.
  logic irqSync;
  logic nmiActive;
  logic irqActive;
  logic isReset;
  logic isNmi;
  logic isIrq;
  logic waiExec;
  logic stpExec;
  logic boundary;

  assign ready    = rdyIn & ce & ~waiExec & ~stpExec;
  assign boundary = lastCycle & ready;

  // ********************
  // nmi edge and irq level capture
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      oldNmiN <= 1'b1;
      nmiSync <= 1'b0;
      irqSync <= 1'b0;
    end
    else if (ce)
    begin
      oldNmiN <= nmiN;
      if (!nmiN && oldNmiN && !nmiSync)
        nmiSync <= 1'b1;
      else if (nmiActive && boundary)
        nmiSync <= 1'b0;
      irqSync <= ~irqN;
    end
  end

  // ********************
  // interrupt taking at instruction boundaries
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      nmiActive <= 1'b0;
      irqActive <= 1'b0;
      intTaken  <= 1'b1;  // reset sequence runs as an interrupt.
      isReset   <= 1'b1;
      isNmi     <= 1'b0;
      isIrq     <= 1'b0;
    end
    else if (rdyIn && ce)
    begin
      nmiActive <= nmiSync;
      irqActive <= ~irqN;
      if (boundary)
      begin
        if (!intTaken)
        begin
          intTaken <= (irqActive & ~iFlag) | nmiActive;
          if (nmiActive)
            nmiActive <= 1'b0;
        end
        else
          intTaken <= 1'b0;
        isReset <= 1'b0;
        isNmi   <= nmiActive;
        isIrq   <= irqActive & ~iFlag;
      end
    end
  end

  // nmi wins over irq.
  always_comb
  begin
    if (isReset)
      hwKind = intReset;
    else if (isNmi)
      hwKind = intNmi;
    else if (isIrq)
      hwKind = intIrq;
    else
      hwKind = intNone;
  end

  // ********************
  // wai and stp
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      waiExec <= 1'b0;
      stpExec <= 1'b0;
    end
    else
    begin
      if (ready && !intTaken && fetch.valid)
      begin
        if (fetch.opcode == `OP_WAI)
          waiExec <= 1'b1;
        else if (fetch.opcode == `OP_STP)
          stpExec <= 1'b1;
      end
      // wake up ignores the i flag.
      if (rdyIn && ce && waiExec && (nmiSync || irqSync || !abortN))
        waiExec <= 1'b0;
    end
  end

  stpHoldsReady: assert property (
    @(posedge CLK) disable iff (!RST_N)
    stpExec |=> (stpExec && !ready)
  );

  takenOnBoundary: assert property (
    @(posedge CLK) disable iff (!RST_N)
    !boundary |=> $stable(intTaken)
  );

endmodule

//--- design/intStatusPkg.sv
`include "intStatus_params.svh"

package intStatusPkg;

  // ********************
  // status register commands
  typedef enum logic [2:0]
  {
    stNone,
    stSep,
    stRep,
    stPlp,
    stXce,
    stFlagOp,
    stIntEntry
  } statusOp_e;

  // data is the sep/rep mask, the pulled byte or the flag opcode.
  typedef struct packed
  {
    statusOp_e            op;
    logic [`DATA_W-1:0]   data;
  } statusCmd_t;

  typedef struct packed
  {
    logic e;  // emulation.
    logic n;
    logic v;
    logic m;
    logic x;
    logic d;
    logic i;
    logic z;
    logic c;
  } statusFlags_t;

  // opcode fetch strobe.
  typedef struct packed
  {
    logic                 valid;
    logic [`DATA_W-1:0]   opcode;
  } fetch_t;

  // ********************
  // interrupt sources
  typedef enum logic [2:0]
  {
    intNone,
    intReset,
    intNmi,
    intIrq,
    intBrk,
    intCop
  } intKind_e;

endpackage

//--- design/intStatusUnit.sv
`timescale 1ns/1ps
`include "intStatus_params.svh"

module intStatusUnit
(
  input  logic                        CLK,
  input  logic                        RST_N,
  input  logic                        ce,
  input  logic                        rdyIn,
  input  logic                        nmiN,
  input  logic                        irqN,
  input  logic                        abortN,
  input  logic                        lastCycle,  // instruction boundary.
  input  intStatusPkg::fetch_t        fetch,
  input  intStatusPkg::statusCmd_t    statusCmd,
  input  logic                        vecPull,
  output logic                        ready,
  output intStatusPkg::statusFlags_t  flags,
  output logic                        intTaken,
  output logic [`ADDR_W-1:0]          vectorAddr,
  output logic [`DATA_W-1:0]          pushStatus,
  output logic                        vpbN
);

  import intStatusPkg::*;

  intKind_e hwKind;

  // ********************
  statusReg uStatus
  (
    .CLK   (CLK),
    .RST_N (RST_N),
    .en    (ready),
    .cmd   (statusCmd),
    .flags (flags)
  );

  intArbiter uArbiter
  (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .ce        (ce),
    .rdyIn     (rdyIn),
    .nmiN      (nmiN),
    .irqN      (irqN),
    .abortN    (abortN),
    .lastCycle (lastCycle),
    .fetch     (fetch),
    .iFlag     (flags.i),
    .ready     (ready),
    .intTaken  (intTaken),
    .hwKind    (hwKind)
  );

  vectorSelect uVector
  (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .en         (ready),
    .fetch      (fetch),
    .intTaken   (intTaken),
    .hwKind     (hwKind),
    .flags      (flags),
    .vecPull    (vecPull),
    .vectorAddr (vectorAddr),
    .pushStatus (pushStatus),
    .vpbN       (vpbN)
  );

endmodule

//--- design/intStatus_params.svh
`ifndef INTSTATUS_PARAMS_SVH
`define INTSTATUS_PARAMS_SVH

// ********************
// widths
`define STATUS_W      9
`define DATA_W        8
`define ADDR_W        24

`define STATUS_RESET  9'b1_0011_0100  // e, m, x and i set.

// ********************
// opcodes
`define OP_WAI        8'hCB
`define OP_STP        8'hDB
`define OP_BRK        8'h00
`define OP_COP        8'h02
`define OP_RTI        8'h40

// ********************
// vectors, low nibble of the low byte
`define VEC_BASE      24'h00FFE0
`define VEC_RESET     4'hC
`define VEC_NMI       4'hA
`define VEC_IRQ       4'hE
`define VEC_COP       4'h4
`define VEC_BRK_NAT   4'h6
`define VEC_BRK_EMU   4'hE

// status bit positions.
`define BIT_C         0
`define BIT_Z         1
`define BIT_I         2
`define BIT_D         3
`define BIT_X         4
`define BIT_M         5
`define BIT_V         6
`define BIT_N         7
`define BIT_E         8

`endif

//--- design/statusReg.sv
`timescale 1ns/1ps
`include "intStatus_params.svh"

module statusReg
(
  input  logic                       CLK,
  input  logic                       RST_N,
  input  logic                       en,
  input  intStatusPkg::statusCmd_t   cmd,
  output intStatusPkg::statusFlags_t flags
);

  import intStatusPkg::*;

  logic [`STATUS_W-1:0] p;
  logic [`STATUS_W-1:0] pNext;
  logic [`DATA_W-1:0]   maskEff;

  // m and x cannot be touched by sep/rep in emulation mode.
  always_comb
  begin
    maskEff = cmd.data;
    maskEff[`BIT_M] = cmd.data[`BIT_M] & ~p[`BIT_E];
    maskEff[`BIT_X] = cmd.data[`BIT_X] & ~p[`BIT_E];
  end

  // ********************
  // next status
  always_comb
  begin
    pNext = p;
    case (cmd.op)
      stSep:
        pNext[`DATA_W-1:0] = p[`DATA_W-1:0] | maskEff;
      stRep:
        pNext[`DATA_W-1:0] = p[`DATA_W-1:0] & ~maskEff;
      stPlp:
      begin
        pNext[`DATA_W-1:0] = cmd.data;
        pNext[`BIT_M] = cmd.data[`BIT_M] | p[`BIT_E];
        pNext[`BIT_X] = cmd.data[`BIT_X] | p[`BIT_E];
      end
      stXce:
      begin
        pNext[`BIT_E] = p[`BIT_C];  // swap carry and emulation.
        pNext[`BIT_C] = p[`BIT_E];
        if (p[`BIT_C])
        begin
          pNext[`BIT_M] = 1'b1;
          pNext[`BIT_X] = 1'b1;
        end
      end
      stFlagOp:
      begin
        // bit 5 of the opcode is the new value.
        case (cmd.data[7:6])
          2'b00:
            pNext[`BIT_C] = cmd.data[5];  // clc/sec.
          2'b01:
            pNext[`BIT_I] = cmd.data[5];  // cli/sei.
          2'b10:
            pNext[`BIT_V] = 1'b0;  // clv.
          default:
            pNext[`BIT_D] = cmd.data[5];  // cld/sed.
        endcase
      end
      stIntEntry:
      begin
        pNext[`BIT_I] = 1'b1;
        pNext[`BIT_D] = 1'b0;
      end
      default:
        pNext = p;
    endcase
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      p <= `STATUS_RESET;
    else if (en)
      p <= pNext;
  end

  assign flags = statusFlags_t'(p);

  // ********************
  // emulation mode keeps 8-bit registers whatever command arrives.
  emuWidthLocked: assert property (
    @(posedge CLK) disable iff (!RST_N)
    p[`BIT_E] |-> (p[`BIT_M] && p[`BIT_X])
  );

endmodule

//--- design/vectorSelect.sv
`timescale 1ns/1ps
`include "intStatus_params.svh"

module vectorSelect
(
  input  logic                        CLK,
  input  logic                        RST_N,
  input  logic                        en,
  input  intStatusPkg::fetch_t        fetch,
  input  logic                        intTaken,
  input  intStatusPkg::intKind_e      hwKind,
  input  intStatusPkg::statusFlags_t  flags,
  input  logic                        vecPull,
  output logic [`ADDR_W-1:0]          vectorAddr,
  output logic [`DATA_W-1:0]          pushStatus,
  output logic                        vpbN
);

  import intStatusPkg::*;

  logic     isBrk;
  logic     isCop;
  intKind_e kind;
  logic [3:0] vecLow;

  // software interrupt kind of the opcode just fetched.
  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      isBrk <= 1'b0;
      isCop <= 1'b0;
    end
    else if (en && !intTaken && fetch.valid)
    begin
      isBrk <= (fetch.opcode == `OP_BRK);
      isCop <= (fetch.opcode == `OP_COP);
    end
  end

  // ********************
  // vector address
  always_comb
  begin
    if (hwKind != intNone)
      kind = hwKind;
    else if (isCop)
      kind = intCop;
    else if (isBrk)
      kind = intBrk;
    else
      kind = intNone;

    case (kind)
      intReset: vecLow = `VEC_RESET;
      intNmi:   vecLow = `VEC_NMI;
      intIrq:   vecLow = `VEC_IRQ;
      intCop:   vecLow = `VEC_COP;
      default:  vecLow = flags.e ? `VEC_BRK_EMU : `VEC_BRK_NAT;
    endcase
  end

  assign vectorAddr = `VEC_BASE | {{(`ADDR_W-5){1'b0}}, flags.e, vecLow};

  // b flag reads as set only for brk/cop in emulation mode.
  assign pushStatus = {flags.n, flags.v, flags.m | flags.e,
                       flags.x & ~(flags.e & intTaken),
                       flags.d, flags.i, flags.z, flags.c};

  assign vpbN = ~vecPull;

endmodule

//--- testbench/intStatusTb.sv
`timescale 1ns/1ps

module intStatusTb;

  import intStatusPkg::*;

  localparam int TAKE_LIMIT  = 16;
  localparam int READY_LIMIT = 32;

  logic         CLK;
  logic         RST_N;
  logic         ce;
  logic         rdyIn;
  logic         nmiN;
  logic         irqN;
  logic         abortN;
  logic         lastCycle;
  fetch_t       fetch;
  statusCmd_t   statusCmd;
  logic         vecPull;
  logic         ready;
  statusFlags_t flags;
  logic         intTaken;
  logic [23:0]  vectorAddr;
  logic [7:0]   pushStatus;
  logic         vpbN;

  statusFlags_t expFlags;  // model of the status register.
  string        testName;
  int           checks;
  int           errors;
  integer       seed;
  integer       r;
  logic         stall;
  statusCmd_t   cmd;

  intStatusUnit DUT
  (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .ce         (ce),
    .rdyIn      (rdyIn),
    .nmiN       (nmiN),
    .irqN       (irqN),
    .abortN     (abortN),
    .lastCycle  (lastCycle),
    .fetch      (fetch),
    .statusCmd  (statusCmd),
    .vecPull    (vecPull),
    .ready      (ready),
    .flags      (flags),
    .intTaken   (intTaken),
    .vectorAddr (vectorAddr),
    .pushStatus (pushStatus),
    .vpbN       (vpbN)
  );

  always #20 CLK = ~CLK;

  // ********************
  // reference model
  function automatic statusFlags_t nextStatus(statusCmd_t c, statusFlags_t f);
    logic [7:0]   p;
    statusFlags_t n;
    p = {f.n, f.v, f.m, f.x, f.d, f.i, f.z, f.c};
    n = f;
    case (c.op)
      stSep, stRep:
      begin
        p = (c.op == stSep) ? (p | c.data) : (p & ~c.data);
        if (f.e)
          p[5:4] = {f.m, f.x};  // width flags locked in emulation.
        n = statusFlags_t'({f.e, p});
      end
      stPlp:
      begin
        p = c.data;
        if (f.e)
          p[5:4] = 2'b11;
        n = statusFlags_t'({f.e, p});
      end
      stXce:
      begin
        n.e = f.c;
        n.c = f.e;
        if (f.c)
        begin
          n.m = 1'b1;
          n.x = 1'b1;
        end
      end
      stFlagOp:
        case (c.data)
          8'h18:   n.c = 1'b0;  // clc.
          8'h38:   n.c = 1'b1;
          8'h58:   n.i = 1'b0;  // cli.
          8'h78:   n.i = 1'b1;
          8'hB8:   n.v = 1'b0;
          8'hD8:   n.d = 1'b0;
          8'hF8:   n.d = 1'b1;
          default: n = f;
        endcase
      stIntEntry:
      begin
        n.i = 1'b1;
        n.d = 1'b0;
      end
      default:
        n = f;
    endcase
    return n;
  endfunction

  function automatic logic [23:0] expectVector(intKind_e kind, logic e);
    logic [3:0] low;
    case (kind)
      intReset: low = 4'hC;
      intNmi:   low = 4'hA;
      intIrq:   low = 4'hE;
      intCop:   low = 4'h4;
      default:  low = e ? 4'hE : 4'h6;  // brk.
    endcase
    return 24'h00FFE0 | {19'd0, e, low};
  endfunction

  // bit 4 doubles as b in emulation mode.
  function automatic logic [7:0] expectPush(statusFlags_t f, logic taken);
    if (f.e)
      return {f.n, f.v, 1'b1, ~taken, f.d, f.i, f.z, f.c};
    else
      return {f.n, f.v, f.m, f.x, f.d, f.i, f.z, f.c};
  endfunction

  function automatic logic [7:0] flagOpcode(input logic [2:0] idx);
    case (idx)
      3'd0:    return 8'h18;
      3'd1:    return 8'h38;
      3'd2:    return 8'h58;
      3'd3:    return 8'h78;
      3'd4:    return 8'hB8;
      3'd5:    return 8'hD8;
      default: return 8'hF8;
    endcase
  endfunction

  always @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      expFlags <= 9'b1_0011_0100;
    else if (rdyIn && ce)
      expFlags <= nextStatus(statusCmd, expFlags);
  end

  // flags are compared every cycle.
  always @(negedge CLK)
  begin
    if (RST_N)
      check({testName, " flags"}, expFlags, flags);
  end

  // ********************
  // helpers
  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic resetDut();
    @(posedge CLK);
    RST_N     <= 1'b0;
    irqN      <= 1'b1;
    nmiN      <= 1'b1;
    lastCycle <= 1'b0;
    fetch     <= '0;
    vecPull   <= 1'b0;
    repeat (4) @(posedge CLK);
    RST_N <= 1'b1;
    @(negedge CLK);
  endtask

  task automatic strobeBoundary();
    @(posedge CLK);
    lastCycle <= 1'b1;
    @(posedge CLK);
    lastCycle <= 1'b0;
    @(negedge CLK);
  endtask

  task automatic issueCmd(input statusOp_e op, input logic [7:0] data);
    @(posedge CLK);
    statusCmd <= '{op, data};
    @(posedge CLK);
    statusCmd <= '{stNone, 8'h00};
    @(negedge CLK);
  endtask

  task automatic fetchOp(input logic [7:0] opcode);
    @(posedge CLK);
    fetch <= '{1'b1, opcode};
    @(posedge CLK);
    fetch <= '0;
    @(negedge CLK);
  endtask

  task automatic goNative();
    issueCmd(stFlagOp, 8'h18);
    issueCmd(stXce, 8'h00);
  endtask

  task automatic waitTaken();
    int n;
    n = 0;
    while (!intTaken && n < TAKE_LIMIT)
    begin
      strobeBoundary();
      n++;
    end
    if (!intTaken)
    begin
      errors++;
      $display("%s: interrupt not taken within %0d boundaries", testName, TAKE_LIMIT);
    end
  endtask

  task automatic waitReady();
    int n;
    n = 0;
    while (!ready && n < READY_LIMIT)
    begin
      @(negedge CLK);
      n++;
    end
    if (!ready)
    begin
      errors++;
      $display("%s: ready did not return within %0d cycles", testName, READY_LIMIT);
    end
  endtask

  // ********************
  // interrupt tests
  task automatic irqTest(input logic emu);
    testName = emu ? "irq emu" : "irq native";
    resetDut();
    strobeBoundary();
    if (!emu)
      goNative();
    @(posedge CLK);
    irqN <= 1'b0;
    repeat (3)
    begin
      strobeBoundary();
      check({testName, " masked"}, 0, intTaken);  // i still set.
    end
    issueCmd(stFlagOp, 8'h58);
    waitTaken();
    check({testName, " vector"}, expectVector(intIrq, emu), vectorAddr);
    check({testName, " push"}, expectPush(expFlags, 1'b1), pushStatus);
    if (emu)
      check({testName, " b"}, 0, pushStatus[4]);
    @(posedge CLK);
    vecPull <= 1'b1;
    @(negedge CLK);
    check({testName, " vpb"}, 0, vpbN);
    @(posedge CLK);
    vecPull <= 1'b0;
    irqN    <= 1'b1;
    @(negedge CLK);
    check({testName, " vpb idle"}, 1, vpbN);
    strobeBoundary();
    check({testName, " done"}, 0, intTaken);
  endtask

  task automatic nmiTest(input logic emu);
    testName = emu ? "nmi emu" : "nmi native";
    resetDut();
    strobeBoundary();
    if (!emu)
      goNative();
    @(posedge CLK);
    nmiN <= 1'b0;
    @(negedge CLK);
    waitTaken();
    check({testName, " vector"}, expectVector(intNmi, emu), vectorAddr);
    // level stays low, so no second edge.
    repeat (4)
    begin
      strobeBoundary();
      check({testName, " held"}, 0, intTaken);
    end
    @(posedge CLK);
    nmiN <= 1'b1;
    @(negedge CLK);
  endtask

  task automatic swTest(input logic emu);
    testName = emu ? "sw emu" : "sw native";
    resetDut();
    strobeBoundary();
    if (!emu)
      goNative();
    fetchOp(8'h00);
    check({testName, " brk vector"}, expectVector(intBrk, emu), vectorAddr);
    check({testName, " brk push"}, expectPush(expFlags, 1'b0), pushStatus);
    if (emu)
      check({testName, " brk b"}, 1, pushStatus[4]);
    fetchOp(8'h02);
    check({testName, " cop vector"}, expectVector(intCop, emu), vectorAddr);
    if (emu)
      check({testName, " cop b"}, 1, pushStatus[4]);
  endtask

  initial
  begin
    seed      = 32'h8df8;
    checks    = 0;
    errors    = 0;
    testName  = "reset";
    CLK       = 1'b0;
    RST_N     = 1'b0;
    ce        = 1'b1;
    rdyIn     = 1'b1;
    nmiN      = 1'b1;
    irqN      = 1'b1;
    abortN    = 1'b1;
    lastCycle = 1'b0;
    fetch     = '0;
    statusCmd = '{stNone, 8'h00};
    vecPull   = 1'b0;

    resetDut();
    check("reset taken", 1, intTaken);
    check("reset vector", expectVector(intReset, 1'b1), vectorAddr);
    strobeBoundary();
    check("reset boundary", 0, intTaken);

    // ********************
    // random status commands
    testName = "status";
    for (int i = 0; i < 200; i++)
    begin
      r = $random(seed);
      cmd.data = r[15:8];
      case (r[2:0])
        3'd0, 3'd1: cmd.op = stSep;
        3'd2, 3'd3: cmd.op = stRep;
        3'd4:       cmd.op = stPlp;
        3'd5:       cmd.op = stXce;
        default:
        begin
          cmd.op   = stFlagOp;
          cmd.data = flagOpcode(r[18:16]);
        end
      endcase
      do
      begin
        r = $random(seed);
        stall = (r[1:0] == 2'b00);
        @(posedge CLK);
        statusCmd <= cmd;
        rdyIn     <= !(stall && r[2]);
        ce        <= !(stall && !r[2]);
      end
      while (stall);
    end
    @(posedge CLK);
    statusCmd <= '{stNone, 8'h00};
    rdyIn     <= 1'b1;
    ce        <= 1'b1;
    @(negedge CLK);

    irqTest(1'b1);
    irqTest(1'b0);
    nmiTest(1'b1);
    nmiTest(1'b0);
    swTest(1'b1);
    swTest(1'b0);

    // ********************
    // wai and stp
    testName = "wai";
    resetDut();
    strobeBoundary();
    fetchOp(8'hCB);
    check("wai halt", 0, ready);
    @(posedge CLK);
    irqN <= 1'b0;
    @(negedge CLK);
    waitReady();
    check("wai wake", 1, ready);
    @(posedge CLK);
    irqN <= 1'b1;
    @(negedge CLK);

    testName = "stp";
    fetchOp(8'hDB);
    check("stp halt", 0, ready);
    @(posedge CLK);
    irqN <= 1'b0;
    nmiN <= 1'b0;
    repeat (4)
    begin
      strobeBoundary();
      check("stp held", 0, ready);
    end
    resetDut();
    check("stp reset", 1, ready);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
